// File: src/graph_pkg.sv
package graph_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths with a meaning
	//////////////////////////////////////////////////////////////////////

	typedef logic [15:0] vertex_id_t;
	typedef logic [15:0] degree_t;
	// Rank and contribution share one unsigned format
	typedef logic [15:0] rank_t;
	typedef logic [31:0] addr_t;

	//////////////////////////////////////////////////////////////////////
	// Bundles
	//////////////////////////////////////////////////////////////////////

	// Work descriptor from the host
	typedef struct packed {
		logic       valid;
		vertex_id_t num_vertices;
		addr_t      contrib_base;
	} wed_t;

	// One vertex from the vertex buffer
	typedef struct packed {
		logic       valid;
		vertex_id_t vertex_id;
		degree_t    out_degree;
		rank_t      rank;
	} vertex_job_t;

	typedef struct packed {
		logic       valid;
		vertex_id_t vertex_id;
		rank_t      contribution;
	} cu_result_t;

	// Toward the write buffer
	typedef struct packed {
		logic  valid;
		addr_t address;
		rank_t data;
	} write_command_t;

	typedef enum logic [1:0] {
		cu_idle,
		cu_divide,
		cu_hold
	} cu_state_t;

endpackage

// File: src/vertex_job_intake.sv
`timescale 1ns/1ns

module vertex_job_intake #(
	parameter int NUM_VERTEX_CU = 2
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     enabled,
	input  graph_pkg::wed_t          wed_request_in,
	input  logic                     vertex_buffer_empty,
	input  graph_pkg::vertex_job_t   vertex_job,
	input  logic [NUM_VERTEX_CU-1:0] cu_busy,
	output logic                     vertex_job_request,
	output logic [NUM_VERTEX_CU-1:0] cu_start,
	output graph_pkg::vertex_job_t   cu_job
);
	import graph_pkg::*;

	wed_t                     wed_latched;
	logic                     wed_valid_prev;
	logic                     wed_edge;
	logic                     request_outstanding;
	vertex_id_t               requested_count;
	logic                     can_request;
	logic [NUM_VERTEX_CU-1:0] free_select;

	assign wed_edge = wed_request_in.valid & ~wed_valid_prev;

	// One request in flight at a time, and only while a unit is free
	assign can_request = enabled & wed_latched.valid & ~vertex_buffer_empty &
		~request_outstanding & (requested_count < wed_latched.num_vertices) & ~(&cu_busy);

	//////////////////////////////////////////////////////////////////////
	// Descriptor and request control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed_latched         <= '0;
			wed_valid_prev      <= 1'b0;
			request_outstanding <= 1'b0;
			requested_count     <= '0;
			vertex_job_request  <= 1'b0;
		end else begin
			wed_valid_prev     <= wed_request_in.valid;
			vertex_job_request <= 1'b0;
			if (wed_edge) begin
				// New run starts from zero
				wed_latched         <= wed_request_in;
				requested_count     <= '0;
				request_outstanding <= 1'b0;
			end else if (can_request) begin
				vertex_job_request  <= 1'b1;
				request_outstanding <= 1'b1;
				requested_count     <= requested_count + 1'b1;
			end else if (vertex_job.valid) begin
				request_outstanding <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Dispatch to the lowest free unit
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		free_select = '0;
		// Walk downward so the lowest free index wins
		for (int k = NUM_VERTEX_CU - 1; k >= 0; k--) begin
			if (!cu_busy[k]) begin
				free_select    = '0;
				free_select[k] = 1'b1;
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_start <= '0;
		end else begin
			cu_start <= vertex_job.valid ? free_select : '0;
		end
	end

	always_ff @(posedge clock) begin
		if (vertex_job.valid) begin
			cu_job <= vertex_job;
		end
	end

endmodule

// File: src/cu_vertex_contribution.sv
`timescale 1ns/1ns

module cu_vertex_contribution (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   start,
	input  graph_pkg::vertex_job_t job,
	input  logic                   ack,
	output logic                   busy,
	output graph_pkg::cu_result_t  result
);
	import graph_pkg::*;

	localparam int W      = $bits(rank_t);
	localparam int STEP_W = $clog2(W);
	localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(W - 1);

	cu_state_t         state;
	logic [STEP_W-1:0] step;
	vertex_id_t        vertex_id;
	degree_t           divisor;
	rank_t             quotient;
	logic [W:0]        remainder;
	logic [W:0]        shifted;
	logic [W:0]        trial;

	//////////////////////////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= cu_idle;
			step  <= '0;
		end else begin
			case (state)
				cu_idle: begin
					if (start) begin
						state <= cu_divide;
						step  <= '0;
					end
				end
				cu_divide: begin
					step <= step + 1'b1;
					// Last of the 16 steps lands the quotient
					if (step == LAST_STEP) begin
						state <= cu_hold;
					end
				end
				cu_hold: begin
					if (ack) begin
						state <= cu_idle;
					end
				end
				default: begin
					state <= cu_idle;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Restoring divider, one quotient bit per clock
	//////////////////////////////////////////////////////////////////////

	assign shifted = {remainder[W-1:0], quotient[W-1]};
	assign trial   = shifted - {1'b0, divisor};

	always_ff @(posedge clock) begin
		if (state == cu_idle && start) begin
			vertex_id <= job.vertex_id;
			divisor   <= job.out_degree;
			// Dividend shifts out of the top as quotient bits shift in
			quotient  <= job.rank;
			remainder <= '0;
		end else if (state == cu_divide) begin
			if (!trial[W]) begin
				remainder <= trial;
				quotient  <= {quotient[W-2:0], 1'b1};
			end else begin
				remainder <= shifted;
				quotient  <= {quotient[W-2:0], 1'b0};
			end
		end
	end

	// Start counts as busy so the intake never picks this unit twice
	assign busy = start | (state != cu_idle);

	always_comb begin
		result.valid        = (state == cu_hold);
		result.vertex_id    = vertex_id;
		// Zero out-degree gives no contribution
		result.contribution = (divisor == '0) ? '0 : quotient;
	end

endmodule

// File: src/write_command_arbiter.sv
`timescale 1ns/1ns

module write_command_arbiter #(
	parameter int NUM_VERTEX_CU = 2
) (
	input  logic                                      clock,
	input  logic                                      rstn,
	input  graph_pkg::wed_t                           wed_request_in,
	input  logic                                      write_buffer_full,
	input  graph_pkg::cu_result_t [NUM_VERTEX_CU-1:0] cu_result,
	output logic [NUM_VERTEX_CU-1:0]                  cu_ack,
	output graph_pkg::write_command_t                 write_command_out,
	output logic                                      done_graph_algorithm
);
	import graph_pkg::*;

	localparam int PTR_W = (NUM_VERTEX_CU > 1) ? $clog2(NUM_VERTEX_CU) : 1;

	logic [PTR_W-1:0] last_grant;
	logic [PTR_W-1:0] grant_index;
	logic             grant_valid;
	logic             wed_valid_prev;
	logic             wed_edge;
	vertex_id_t       write_count;
	cu_result_t       picked;

	assign wed_edge = wed_request_in.valid & ~wed_valid_prev;

	//////////////////////////////////////////////////////////////////////
	// Round robin starting after the last granted unit
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		int idx;
		grant_valid = 1'b0;
		grant_index = last_grant;
		cu_ack      = '0;
		for (int off = 1; off <= NUM_VERTEX_CU; off++) begin
			idx = (int'(last_grant) + off) % NUM_VERTEX_CU;
			// Full buffer stalls every result in place
			if (!grant_valid && !write_buffer_full && cu_result[idx].valid) begin
				grant_valid = 1'b1;
				grant_index = PTR_W'(idx);
			end
		end
		if (grant_valid) begin
			cu_ack[grant_index] = 1'b1;
		end
	end

	assign picked = cu_result[grant_index];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_grant        <= '0;
			write_command_out <= '0;
		end else begin
			write_command_out.valid <= grant_valid;
			if (grant_valid) begin
				last_grant                <= grant_index;
				write_command_out.address <= wed_request_in.contrib_base +
					addr_t'(picked.vertex_id);
				write_command_out.data    <= picked.contribution;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Completion count and done
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed_valid_prev       <= 1'b0;
			write_count          <= '0;
			done_graph_algorithm <= 1'b0;
		end else begin
			wed_valid_prev <= wed_request_in.valid;
			if (wed_edge) begin
				write_count          <= '0;
				done_graph_algorithm <= 1'b0;
			end else begin
				if (grant_valid) begin
					write_count <= write_count + 1'b1;
				end
				// Sticky until the next descriptor
				if (wed_request_in.valid && write_count == wed_request_in.num_vertices) begin
					done_graph_algorithm <= 1'b1;
				end
			end
		end
	end

endmodule

// File: src/cu_graph_algorithm_control.sv
`timescale 1ns/1ns

module cu_graph_algorithm_control #(
	parameter int NUM_VERTEX_CU = 2
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enabled,
	input  graph_pkg::wed_t           wed_request_in,
	input  logic                      vertex_buffer_empty,
	input  graph_pkg::vertex_job_t    vertex_job,
	output logic                      vertex_job_request,
	input  logic                      write_buffer_full,
	output graph_pkg::write_command_t write_command_out,
	output logic                      done_graph_algorithm
);
	import graph_pkg::*;

	logic [NUM_VERTEX_CU-1:0]       cu_start;
	logic [NUM_VERTEX_CU-1:0]       cu_busy;
	logic [NUM_VERTEX_CU-1:0]       cu_ack;
	vertex_job_t                    cu_job;
	cu_result_t [NUM_VERTEX_CU-1:0] cu_result;

	//////////////////////////////////////////////////////////////////////
	// Job intake and dispatch
	//////////////////////////////////////////////////////////////////////

	vertex_job_intake #(
		.NUM_VERTEX_CU(NUM_VERTEX_CU)
	) vertex_job_intake_i (
		.clock              (clock),
		.rstn               (rstn),
		.enabled            (enabled),
		.wed_request_in     (wed_request_in),
		.vertex_buffer_empty(vertex_buffer_empty),
		.vertex_job         (vertex_job),
		.cu_busy            (cu_busy),
		.vertex_job_request (vertex_job_request),
		.cu_start           (cu_start),
		.cu_job             (cu_job)
	);

	// Shared job bus with one start strobe per unit
	generate
		for (genvar i = 0; i < NUM_VERTEX_CU; i++) begin : gen_vertex_cu
			cu_vertex_contribution cu_vertex_contribution_i (
				.clock (clock),
				.rstn  (rstn),
				.start (cu_start[i]),
				.job   (cu_job),
				.ack   (cu_ack[i]),
				.busy  (cu_busy[i]),
				.result(cu_result[i])
			);
		end
	endgenerate

	//////////////////////////////////////////////////////////////////////
	// Result collection and write commands
	//////////////////////////////////////////////////////////////////////

	write_command_arbiter #(
		.NUM_VERTEX_CU(NUM_VERTEX_CU)
	) write_command_arbiter_i (
		.clock               (clock),
		.rstn                (rstn),
		.wed_request_in      (wed_request_in),
		.write_buffer_full   (write_buffer_full),
		.cu_result           (cu_result),
		.cu_ack              (cu_ack),
		.write_command_out   (write_command_out),
		.done_graph_algorithm(done_graph_algorithm)
	);

endmodule

// File: testbench/cu_graph_algorithm_control_checker.sv
`timescale 1ns/1ns

module cu_graph_algorithm_control_checker (
	input logic                      clock,
	input logic                      rstn,
	input graph_pkg::wed_t           wed_request_in,
	input logic                      vertex_job_request,
	input logic                      write_buffer_full,
	input graph_pkg::write_command_t write_command_out,
	input logic                      done_graph_algorithm
);

	//////////////////////////////////////////////////////////////////////
	// Port rules
	//////////////////////////////////////////////////////////////////////

	// Full buffer in one cycle blocks the command in the next
	property no_write_after_full;
		@(posedge clock) disable iff (!rstn)
		$past(write_buffer_full) |-> !write_command_out.valid;
	endproperty

	property single_cycle_request;
		@(posedge clock) disable iff (!rstn)
		vertex_job_request |=> !vertex_job_request;
	endproperty

	// Done only drops one cycle after a descriptor rising edge
	property done_cleared_by_descriptor;
		@(posedge clock) disable iff (!rstn)
		$fell(done_graph_algorithm) |->
			($past(wed_request_in.valid) && !$past(wed_request_in.valid, 2));
	endproperty

	assert property (no_write_after_full)
		else $error("write command issued one cycle after write_buffer_full");
	assert property (single_cycle_request)
		else $error("vertex_job_request high on two cycles in a row");
	assert property (done_cleared_by_descriptor)
		else $error("done_graph_algorithm fell without a new descriptor");

endmodule

// File: testbench/cu_graph_algorithm_control_tb.sv
`timescale 1ns/1ns

module cu_graph_algorithm_control_tb;
	import graph_pkg::*;

	localparam int TIMEOUT_CYCLES = 5000;
	localparam int MAX_VERTICES   = 64;

	logic           clock;
	logic           rstn;
	logic           enabled;
	wed_t           wed_request_in;
	logic           vertex_buffer_empty;
	vertex_job_t    vertex_job;
	logic           vertex_job_request;
	logic           write_buffer_full;
	write_command_t write_command_out;
	logic           done_graph_algorithm;

	integer     seed      = 1536;
	integer     full_seed = 1536;
	rank_t      job_rank   [MAX_VERTICES];
	degree_t    job_degree [MAX_VERTICES];
	bit         sent       [MAX_VERTICES];
	bit         written    [MAX_VERTICES];
	int         run_vertices;
	int         write_total;
	int         zero_degree_writes;
	int         checks;
	int         errors;
	int         buffer_delay;
	addr_t      run_base;
	bit         run_active;
	bit         full_random;
	vertex_id_t next_id;

	cu_graph_algorithm_control #(
		.NUM_VERTEX_CU(2)
	) cu_graph_algorithm_control_i (
		.clock               (clock),
		.rstn                (rstn),
		.enabled             (enabled),
		.wed_request_in      (wed_request_in),
		.vertex_buffer_empty (vertex_buffer_empty),
		.vertex_job          (vertex_job),
		.vertex_job_request  (vertex_job_request),
		.write_buffer_full   (write_buffer_full),
		.write_command_out   (write_command_out),
		.done_graph_algorithm(done_graph_algorithm)
	);

	bind cu_graph_algorithm_control cu_graph_algorithm_control_checker checker_i (.*);

	always #10 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic rank_t expected_contribution(input rank_t rank, input degree_t degree);
		if (degree == 0)
			return '0;
		return rank / degree;
	endfunction

	function automatic addr_t expected_address(input addr_t base, input vertex_id_t id);
		return base + {16'h0000, id};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Vertex buffer and write buffer models
	//////////////////////////////////////////////////////////////////////

	// Answers each request 1 to 4 cycles later with ids in order
	always begin
		@(negedge clock);
		if (vertex_job_request) begin
			buffer_delay = 1 + ($unsigned($random(seed)) % 4);
			repeat (buffer_delay - 1) @(negedge clock);
			vertex_job.valid     = 1'b1;
			vertex_job.vertex_id = next_id;
			vertex_job.rank      = rank_t'($random(seed));
			if (next_id % 5 == 2)
				vertex_job.out_degree = '0;
			else
				vertex_job.out_degree = degree_t'($random(seed) & 31);
			job_rank[next_id]   = vertex_job.rank;
			job_degree[next_id] = vertex_job.out_degree;
			sent[next_id]       = 1'b1;
			next_id             = next_id + 1'b1;
			@(negedge clock);
			vertex_job.valid = 1'b0;
		end
	end

	always @(negedge clock) begin
		if (full_random)
			write_buffer_full = ($unsigned($random(full_seed)) % 3) == 0;
		else
			write_buffer_full = 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Compare process
	//////////////////////////////////////////////////////////////////////

	task automatic check_write(input write_command_t cmd);
		int    id;
		rank_t expected_data;
		id = -1;
		// Look for the handed out vertex whose address this is
		for (int i = 0; i < run_vertices; i++) begin
			if (sent[i] && cmd.address == expected_address(run_base, vertex_id_t'(i)))
				id = i;
		end
		checks++;
		if (id < 0) begin
			errors++;
			$display("Write to address %h matches no requested vertex", cmd.address);
		end else if (written[id]) begin
			errors++;
			$display("Vertex %0d written a second time", id);
		end else begin
			written[id] = 1'b1;
			write_total++;
			expected_data = expected_contribution(job_rank[id], job_degree[id]);
			if (job_degree[id] == '0)
				zero_degree_writes++;
			checks++;
			if (cmd.data !== expected_data) begin
				errors++;
				$display("CHECK FAILED write data v%0d: expected %h, actual %h", id,
					expected_data, cmd.data);
			end
		end
	endtask

	always @(negedge clock) begin
		if (rstn && write_command_out.valid)
			check_write(write_command_out);
		if (run_active && done_graph_algorithm && write_total < run_vertices) begin
			errors++;
			$display("done_graph_algorithm high after only %0d of %0d writes",
				write_total, run_vertices);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Sequencing helpers
	//////////////////////////////////////////////////////////////////////

	task automatic print_counts();
		$display("Checks: %0d  Writes: %0d  Errors: %0d", checks, write_total, errors);
	endtask

	task automatic abort_on_timeout(input string what);
		errors++;
		$display("Timed out waiting for %s", what);
		print_counts();
		$display("STATUS: FAIL");
		$finish;
	endtask

	task automatic wait_for_writes(input int count);
		int cycles;
		cycles = 0;
		while (write_total < count && cycles < TIMEOUT_CYCLES) begin
			@(negedge clock);
			cycles++;
		end
		if (write_total < count)
			abort_on_timeout("write commands");
	endtask

	task automatic wait_for_done(input string what);
		int cycles;
		cycles = 0;
		while (!done_graph_algorithm && cycles < TIMEOUT_CYCLES) begin
			@(negedge clock);
			cycles++;
		end
		if (!done_graph_algorithm)
			abort_on_timeout(what);
	endtask

	// Drops valid for a cycle, then presents the new descriptor
	task automatic start_run(input vertex_id_t count, input addr_t base);
		run_active           = 1'b0;
		wed_request_in.valid = 1'b0;
		@(negedge clock);
		for (int i = 0; i < MAX_VERTICES; i++) begin
			sent[i]    = 1'b0;
			written[i] = 1'b0;
		end
		run_vertices                = count;
		run_base                    = base;
		write_total                 = 0;
		zero_degree_writes          = 0;
		next_id                     = '0;
		wed_request_in.num_vertices = count;
		wed_request_in.contrib_base = base;
		wed_request_in.valid        = 1'b1;
		@(negedge clock);
		checks++;
		if (done_graph_algorithm) begin
			errors++;
			$display("done_graph_algorithm still high after a new descriptor");
		end
		run_active = 1'b1;
	endtask

	task automatic verify_run(input string name);
		for (int i = 0; i < run_vertices; i++) begin
			checks++;
			if (!written[i]) begin
				errors++;
				$display("%s: vertex %0d was never written", name, i);
			end
		end
		checks++;
		if (write_total != run_vertices) begin
			errors++;
			$display("CHECK FAILED %s write count: expected %0d, actual %0d", name,
				run_vertices, write_total);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		clock               = 1'b0;
		rstn                = 1'b0;
		enabled             = 1'b1;
		wed_request_in      = '0;
		vertex_buffer_empty = 1'b0;
		vertex_job          = '0;
		write_buffer_full   = 1'b0;
		full_random         = 1'b0;
		run_active          = 1'b0;
		run_vertices        = 0;
		run_base            = '0;
		write_total         = 0;
		checks              = 0;
		errors              = 0;
		next_id             = '0;
		repeat (16) @(negedge clock);
		rstn = 1'b1;

		// Quiet outputs with no descriptor yet
		for (int i = 0; i < 20; i++) begin
			@(negedge clock);
			checks++;
			if (vertex_job_request || write_command_out.valid || done_graph_algorithm) begin
				errors++;
				$display("Output activity after reset before any descriptor");
			end
		end

		full_random = 1'b1;
		start_run(16'd20, 32'h0000_1000);
		wait_for_writes(5);

		// Pause mid run with requests blocked
		enabled = 1'b0;
		@(negedge clock);
		for (int i = 0; i < 40; i++) begin
			@(negedge clock);
			checks++;
			if (vertex_job_request) begin
				errors++;
				$display("Request pulse while enabled is low");
			end
		end
		enabled = 1'b1;
		wait_for_done("done of the first run");
		repeat (10) @(negedge clock);
		verify_run("first run");
		checks++;
		if (zero_degree_writes == 0) begin
			errors++;
			$display("No vertex with out-degree zero was written");
		end

		start_run(16'd7, 32'h0000_8000);
		wait_for_done("done of the second run");
		repeat (10) @(negedge clock);
		verify_run("second run");

		print_counts();
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: graph_control.f
src/graph_pkg.sv
src/vertex_job_intake.sv
src/cu_vertex_contribution.sv
src/write_command_arbiter.sv
src/cu_graph_algorithm_control.sv
testbench/cu_graph_algorithm_control_checker.sv
testbench/cu_graph_algorithm_control_tb.sv
